/* verilog/hash_cfg.svh */
//################################################
// Hash engine configuration
//################################################

`ifndef HASH_CFG_SVH
`define HASH_CFG_SVH

// Message word and folded value widths
`define HASH_DATA_W 32
`define HASH_W      16

// State rotation before each absorb
`define HASH_ROT    5
`define HASH_INIT   16'hFFFF

// Word counter wraps modulo 256
`define HASH_CNT_W  8

`endif

/* verilog/hash_pkg.sv */
//################################################
// Hash engine shared types
//################################################

`include "hash_cfg.svh"

`default_nettype none

package hash_pkg;

    // One message word as it arrives
    typedef logic [`HASH_DATA_W-1:0] word_t;

    // Folded value or running hash state
    typedef logic [`HASH_W-1:0] digest_t;

    // Number of words in a message
    typedef logic [`HASH_CNT_W-1:0] count_t;

    // Mixer phase
    // FRESH means the next word starts a new message
    typedef enum logic {
        PHASE_FRESH  = 1'b0,
        PHASE_ABSORB = 1'b1
    } absorb_phase_t;

endpackage

`default_nettype wire

/* verilog/block_fold.sv */
//################################################
// Input fold stage
//################################################

`timescale 1ns/1ns

`include "hash_cfg.svh"

`default_nettype none

module block_fold
    import hash_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  word_t   in_data,
    input  logic    in_last,
    output logic    fold_valid,
    output digest_t fold_value,
    output logic    fold_last
);

    digest_t folded;

    // Low half XOR high half of the word
    always_comb begin
        folded = in_data[`HASH_W-1:0] ^ in_data[`HASH_DATA_W-1:`HASH_W];
    end

    // Strobe follows the input by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fold_valid <= 1'b0;
        end else begin
            fold_valid <= in_valid;
        end
    end

    // Payload only moves on a strobed word
    always_ff @(posedge clk) begin
        if (in_valid) begin
            fold_value <= folded;
            fold_last  <= in_last;
        end
    end

    // Every word carries two halves of the digest width
    initial begin
        if (`HASH_DATA_W != 2 * `HASH_W) begin
            $error("word width must be twice the digest width");
        end
    end

endmodule

`default_nettype wire

/* verilog/state_mixer.sv */
//################################################
// Running state mixer
//################################################

`timescale 1ns/1ns

`include "hash_cfg.svh"

`default_nettype none

module state_mixer
    import hash_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    fold_valid,
    input  digest_t fold_value,
    input  logic    fold_last,
    output logic    mix_valid,
    output digest_t mix_state,
    output count_t  mix_count,
    output logic    mix_last
);

    absorb_phase_t phase;

    digest_t start_state;
    digest_t rotated;
    digest_t next_state;
    count_t  next_count;

    // Mixing rule for the word at the input
    always_comb begin
        // First word of a message starts from the initial state
        if (phase == PHASE_FRESH) begin
            start_state = `HASH_INIT;
            next_count  = count_t'(1);
        end else begin
            start_state = mix_state;
            next_count  = mix_count + count_t'(1);
        end

        rotated = {start_state[`HASH_W-1-`HASH_ROT:0],
                   start_state[`HASH_W-1:`HASH_W-`HASH_ROT]};
        next_state = rotated ^ fold_value;
    end

    // Phase register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= PHASE_FRESH;
        end else if (fold_valid) begin
            // A last word rearms the mixer for the next message
            phase <= fold_last ? PHASE_FRESH : PHASE_ABSORB;
        end
    end

    // Running state and word count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mix_state <= `HASH_INIT;
            mix_count <= '0;
        end else if (fold_valid) begin
            mix_state <= next_state;
            mix_count <= next_count;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mix_valid <= 1'b0;
        end else begin
            mix_valid <= fold_valid;
        end
    end

    // Last flag travels with the state
    always_ff @(posedge clk) begin
        if (fold_valid) begin
            mix_last <= fold_last;
        end
    end

    // A word that is not the last leaves a message in progress
    property p_absorb_after_word;
        @(posedge clk) disable iff (!rst_n)
        (fold_valid && !fold_last) |=> (phase == PHASE_ABSORB);
    endproperty
    a_absorb_after_word: assert property (p_absorb_after_word)
        else $error("mixer not in ABSORB after a non-last word");

    // Output strobe only ever answers a folded word
    property p_valid_has_source;
        @(posedge clk) disable iff (!rst_n)
        ($past(rst_n, 2) && mix_valid) |-> $past(fold_valid);
    endproperty
    a_valid_has_source: assert property (p_valid_has_source)
        else $error("mix_valid without a folded word one cycle earlier");

endmodule

`default_nettype wire

/* verilog/digest_emitter.sv */
//################################################
// Digest output stage
//################################################

`timescale 1ns/1ns

`include "hash_cfg.svh"

`default_nettype none

module digest_emitter
    import hash_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    mix_valid,
    input  digest_t mix_state,
    input  count_t  mix_count,
    input  logic    mix_last,
    output logic    digest_valid,
    output digest_t digest,
    output count_t  word_count
);

    logic msg_done;

    // Final word of a message reached the emitter
    always_comb begin
        msg_done = mix_valid && mix_last;
    end

    // One-cycle result strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digest_valid <= 1'b0;
        end else begin
            digest_valid <= msg_done;
        end
    end

    // Result holds until the next message ends
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digest     <= '0;
            word_count <= '0;
        end else if (msg_done) begin
            digest     <= mix_state;
            word_count <= mix_count;
        end
    end

    // Back-to-back strobes need two one-word messages in a row
    property p_no_stuck_valid;
        @(posedge clk) disable iff (!rst_n)
        (digest_valid && $past(digest_valid))
            |-> ($past(mix_valid && mix_last) && $past(mix_valid && mix_last, 2));
    endproperty
    a_no_stuck_valid: assert property (p_no_stuck_valid)
        else $error("digest_valid held without two last words before it");

endmodule

`default_nettype wire

/* verilog/hash_top.sv */
//################################################
// Streaming hash engine top
//################################################

`timescale 1ns/1ns

`include "hash_cfg.svh"

`default_nettype none

module hash_top
    import hash_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  word_t   in_data,
    input  logic    in_last,
    output logic    digest_valid,
    output digest_t digest,
    output count_t  word_count
);

    // Fold stage to mixer
    wire          fold_valid;
    wire digest_t fold_value;
    wire          fold_last;

    // Mixer to emitter
    wire          mix_valid;
    wire digest_t mix_state;
    wire count_t  mix_count;
    wire          mix_last;

    block_fold u_fold (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_last    (in_last),
        .fold_valid (fold_valid),
        .fold_value (fold_value),
        .fold_last  (fold_last)
    );

    state_mixer u_mixer (
        .clk        (clk),
        .rst_n      (rst_n),
        .fold_valid (fold_valid),
        .fold_value (fold_value),
        .fold_last  (fold_last),
        .mix_valid  (mix_valid),
        .mix_state  (mix_state),
        .mix_count  (mix_count),
        .mix_last   (mix_last)
    );

    // Result appears three cycles after the last word
    digest_emitter u_emit (
        .clk          (clk),
        .rst_n        (rst_n),
        .mix_valid    (mix_valid),
        .mix_state    (mix_state),
        .mix_count    (mix_count),
        .mix_last     (mix_last),
        .digest_valid (digest_valid),
        .digest       (digest),
        .word_count   (word_count)
    );

endmodule

`default_nettype wire

/* tests/hash_checker.sv */
//################################################
// Hash engine result checker
//################################################

`timescale 1ns/1ns

`default_nettype none

module hash_checker
    import hash_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  logic    in_last,
    input  logic    digest_valid,
    input  digest_t digest,
    input  count_t  word_count
);

    // Input and output both sampled at the edge, three register stages apart
    localparam int LATENCY = 3;

    string   exp_name_q[$];
    digest_t exp_digest_q[$];
    count_t  exp_count_q[$];
    int      last_edge_q[$];

    int edge_count = 0;
    bit first_seen = 1'b0;
    bit idle_bad   = 1'b0;
    int pass_count = 0;
    int fail_count = 0;

    task automatic push_expected(input string name, input digest_t exp_digest,
                                 input count_t exp_count);
        exp_name_q.push_back(name);
        exp_digest_q.push_back(exp_digest);
        exp_count_q.push_back(exp_count);
    endtask

    function automatic int pending_count();
        return exp_name_q.size();
    endfunction

    function automatic string head_name();
        string name;
        if (exp_name_q.size() == 0) begin
            name = "none";
        end else begin
            name = exp_name_q[0];
        end
        return name;
    endfunction

    task automatic note_failure(input string what);
        $display("%s", what);
        fail_count++;
    endtask

    task automatic print_counts();
        $display("tests passed %0d failed %0d", pass_count, fail_count);
    endtask

    // Outputs stay cleared until the first message completes
    task automatic check_idle();
        if (!idle_bad && (digest_valid !== 1'b0 || digest !== '0 || word_count !== '0)) begin
            $display("error reset_idle expected digest 0000 count 0 actual digest %h count %0d",
                     digest, word_count);
            idle_bad = 1'b1;
            fail_count++;
        end
    endtask

    task automatic check_result();
        string   name;
        digest_t exp_digest;
        count_t  exp_count;
        int      latency;
        bit      ok;
        if (!first_seen) begin
            first_seen = 1'b1;
            if (!idle_bad) begin
                $display("pass reset_idle");
                pass_count++;
            end
        end
        latency = -1;
        if (last_edge_q.size() != 0) begin
            latency = edge_count - last_edge_q.pop_front();
        end
        if (exp_name_q.size() == 0) begin
            note_failure($sformatf("digest_valid arrived with no message pending (digest %h)",
                                   digest));
        end else begin
            name       = exp_name_q.pop_front();
            exp_digest = exp_digest_q.pop_front();
            exp_count  = exp_count_q.pop_front();
            ok         = 1'b1;
            if (digest !== exp_digest) begin
                $display("error %s digest expected %h actual %h", name, exp_digest, digest);
                ok = 1'b0;
            end
            if (word_count !== exp_count) begin
                $display("error %s count expected %0d actual %0d", name, exp_count, word_count);
                ok = 1'b0;
            end
            if (latency < 0) begin
                $display("%s finished although no last word was strobed", name);
                ok = 1'b0;
            end else if (latency != LATENCY) begin
                $display("error %s latency expected %0d actual %0d", name, LATENCY, latency);
                ok = 1'b0;
            end
            if (ok) begin
                $display("pass %s digest %h count %0d", name, digest, word_count);
                pass_count++;
            end else begin
                fail_count++;
            end
        end
    endtask

    always @(posedge clk) begin
        edge_count = edge_count + 1;
        if (rst_n === 1'b1) begin
            // Edge at which the DUT takes the final word of a message
            if (in_valid === 1'b1 && in_last === 1'b1) begin
                last_edge_q.push_back(edge_count);
            end
            if (digest_valid === 1'b1) begin
                check_result();
            end else if (!first_seen) begin
                check_idle();
            end
        end
    end

endmodule

`default_nettype wire

/* tests/hash_tb.sv */
//################################################
// Hash engine testbench
//################################################

`timescale 1ns/1ns

`default_nettype none

module hash_tb
    import hash_pkg::*;
();

    localparam string GOLDEN_FILE = "tests/hash_golden.txt";
    localparam int    DRAIN_LIMIT = 64;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    word_t   in_data;
    logic    in_last;
    logic    digest_valid;
    digest_t digest;
    count_t  word_count;

    integer seed;
    int     msg_sent;

    // Words of the message being assembled from the file
    word_t msg_words[$];
    bit    msg_lasts[$];

    hash_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_last      (in_last),
        .digest_valid (digest_valid),
        .digest       (digest),
        .word_count   (word_count)
    );

    hash_checker chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_last      (in_last),
        .digest_valid (digest_valid),
        .digest       (digest),
        .word_count   (word_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Packed text from $fscanf, leading null bytes dropped
    function automatic string text_of(input logic [8*32-1:0] raw);
        string s;
        int    i;
        s = "";
        for (i = 31; i >= 0; i--) begin
            if (raw[i*8 +: 8] != 8'h00) begin
                s = {s, $sformatf("%c", raw[i*8 +: 8])};
            end
        end
        return s;
    endfunction

    task automatic drive_word(input word_t word, input bit last);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_data  = word;
        in_last  = last;
    endtask

    task automatic drive_idle(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            in_last  = 1'b0;
        end
    endtask

    task automatic drive_message();
        int i;
        for (i = 0; i < msg_words.size(); i++) begin
            drive_word(msg_words[i], msg_lasts[i]);
        end
        msg_words.delete();
        msg_lasts.delete();
    endtask

    task automatic run_golden_file();
        integer           fd;
        integer           code;
        logic [8*32-1:0]  tag;
        logic [8*32-1:0]  name_raw;
        logic [8*256-1:0] rest;
        word_t            word;
        int               run_len;
        int               last_flag;
        digest_t          exp_digest;
        count_t           exp_count;
        int               gap;
        int               i;
        bit               done;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            chk.note_failure($sformatf("cannot open %s", GOLDEN_FILE));
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, "%s", tag);
                if (code != 1) begin
                    done = 1'b1;
                end else if (tag == "#") begin
                    code = $fgets(rest, fd);
                end else if (tag == "w") begin
                    code = $fscanf(fd, "%h %d", word, last_flag);
                    msg_words.push_back(word);
                    msg_lasts.push_back(last_flag != 0);
                end else if (tag == "r") begin
                    code = $fscanf(fd, "%h %d %d", word, run_len, last_flag);
                    for (i = 0; i < run_len; i++) begin
                        msg_words.push_back(word);
                        msg_lasts.push_back((i == run_len - 1) && (last_flag != 0));
                    end
                end else if (tag == "e") begin
                    code = $fscanf(fd, "%s %h %h %d", name_raw, exp_digest, exp_count, gap);
                    chk.push_expected(text_of(name_raw), exp_digest, exp_count);
                    drive_message();
                    msg_sent++;
                    if (gap < 0) begin
                        gap = $unsigned($random(seed)) % 4;
                    end
                    drive_idle(gap);
                end else begin
                    chk.note_failure($sformatf("golden file has an unknown line tag %s",
                                               text_of(tag)));
                    done = 1'b1;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (chk.pending_count() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (chk.pending_count() != 0) begin
            chk.note_failure($sformatf("timeout: message %s never finished within %0d cycles",
                                       chk.head_name(), DRAIN_LIMIT));
        end
    endtask

    initial begin
        seed     = 84;
        msg_sent = 0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        in_last  = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Quiet stretch so the cleared outputs are seen before any message
        drive_idle(4);
        run_golden_file();
        drive_idle(1);
        wait_for_drain();
        if (msg_sent == 0) begin
            chk.note_failure("no messages were read from the golden file");
        end
        chk.print_counts();
        if (chk.fail_count == 0 && chk.pass_count > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+verilog
verilog/hash_pkg.sv
verilog/block_fold.sv
verilog/state_mixer.sv
verilog/digest_emitter.sv
verilog/hash_top.sv
tests/hash_checker.sv
tests/hash_tb.sv

/* Makefile */
# Streaming hash engine, Verilator flow

TOP_TB  = hash_tb
TOP_RTL = hash_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP_RTL)

obj_dir/$(TOP_TB): project.f verilog/*.sv verilog/*.svh tests/*.sv
	verilator --binary --timing -j 0 -f project.f --top-module $(TOP_TB) -o $(TOP_TB)

# A run that stops before its verdict line counts as a failure too
sim: obj_dir/$(TOP_TB)
	./obj_dir/$(TOP_TB) | tee sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/hash_golden.txt */
# w <word> <last>: one message word; r <word> <n> <last>: same word n times, last on final one
# e <name> <digest> <count> <gap>: end of message, expected result, idle cycles after (-1 random)
w 12345678 1
e one_word bbb3 01 2
w deadbeef 0
w cafef00d 0
w 00000001 0
w 80000000 1
e multi_word 8315 04 0
w 0000ffff 0
w 11112222 1
e b2b_two 3333 02 0
w 0f0f0000 1
e b2b_one_a f0f0 01 0
w 00000000 1
e b2b_one_b ffff 01 -1
r a5a5a5a4 299 0
w 00010000 1
e long_300 1842 2c -1
r 13579bdf 256 1
e long_256 ffff 00 -1
w ffff0000 0
w 00000000 1
e zero_digest 0000 02 -1
